// File: sht10Top.f
verilog/sensorPkg.sv
verilog/busTimingPkg.sv
verilog/shtClockGen.sv
verilog/shtSequencer.sv
verilog/bcdConverter.sv
verilog/sht10Top.sv
tb/sht10Model.sv
tb/sht10Tb.sv

// File: Makefile
# Verilator flow for the SHT10 humidity front end

VERILATOR ?= verilator
TB_TOP    ?= sht10Tb
RTL_TOP   ?= sht10Top
FILELIST  ?= sht10Top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/sht10Tb.sv
////////////////////////////////////////////////////////////
// Testbench for the SHT10 humidity front end
// Random samples, ready delays and sensor faults, checked
// against expected raw value, BCD digits and strobe timing
////////////////////////////////////////////////////////////

module sht10Tb;
	import sensorPkg::*;

	localparam int HalfSlot   = 4;
	localparam int PowerUp    = 50;
	localparam int Timeout    = 400;
	localparam int NumRuns    = 40;
	localparam int SlotCycles = 2 * HalfSlot;
	// 4 start, 8 command, 1 ack, 18 read slots plus the ready wait
	localparam int MeasBound  = 31 * SlotCycles + Timeout + 2 * SlotCycles;
	localparam int CycleLimit = NumRuns * (MeasBound + 100) + PowerUp + 10;

	logic         CLK;
	logic         rst;
	logic         startMeas;
	logic         sdaIn;
	logic         sck;
	logic         sdaDrive;
	logic         busy;
	logic         ready;
	logic         rawValid;
	logic         sensorError;
	logic         bcdValid;
	rawSample_t   rawValue;
	bcdHumidity_t humidityBcd;

	////////////////////////////////////////////////////////////
	// Sensor model controls
	rawSample_t modelValue;
	logic       ackEnable;
	logic       readyEnable;
	int         readyDelay;
	int         cmdCount;
	logic       busError;

	int cycleCount = 0;
	int seed;

	sht10Top #(
		.HalfSlotCycles(HalfSlot), .PowerUpCycles(PowerUp), .MeasureTimeoutCycles(Timeout)
	) uut (
		.CLK(CLK), .rst(rst), .startMeas(startMeas), .sdaIn(sdaIn), .sck(sck),
		.sdaDrive(sdaDrive), .busy(busy), .ready(ready), .rawValid(rawValid),
		.sensorError(sensorError), .bcdValid(bcdValid), .rawValue(rawValue),
		.humidityBcd(humidityBcd)
	);

	sht10Model sensor (
		.CLK(CLK), .rst(rst), .sck(sck), .sdaDrive(sdaDrive), .sdaIn(sdaIn),
		.sampleValue(modelValue), .ackEnable(ackEnable), .readyEnable(readyEnable),
		.readyDelay(readyDelay), .cmdCount(cmdCount), .busError(busError)
	);

	initial
	begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic stopRun(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at cycle %0d", cycleCount);
	endtask

	task automatic checkRaw(input string name, input rawSample_t expected, input rawSample_t actual);
		if (actual !== expected)
			stopRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkBcd(input string name, input bcdHumidity_t expected,
		input bcdHumidity_t actual);
		if (actual !== expected)
			stopRun($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopRun($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected)
			stopRun($sformatf("CHECK FAILED %s expected %0d actual %0d", name, expected, actual));
	endtask

	// Decimal digits, thousands on top
	function automatic bcdHumidity_t decimalDigits(input rawSample_t value);
		int v;
		v = int'(value);
		return {4'(v / 1000), 4'((v / 100) % 10), 4'((v / 10) % 10), 4'(v % 10)};
	endfunction

	// Idle bus, no strobes
	task automatic checkQuiet(input string name);
		checkFlag({name, " busy"}, 1'b0, busy);
		checkFlag({name, " sck"}, 1'b0, sck);
		checkFlag({name, " sdaDrive"}, 1'b0, sdaDrive);
		checkFlag({name, " strobes"}, 1'b0, rawValid || sensorError || bcdValid);
	endtask

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
			stopRun("Run went past its cycle limit");
		if (busError)
			stopRun("Sensor model saw a protocol error on the bus");
	end

	initial
	begin
		rawSample_t value;
		int         lowCycles;
		int         waitCycles;
		int         extraAt;
		int         faultDraw;
		int         expectedCmds;
		logic       expectGood;
		logic       sendExtra;
		logic       gotRaw;
		logic       gotErr;

		seed         = 32'h46ca;
		rst          = 1'b1;
		startMeas    = 1'b0;
		modelValue   = '0;
		ackEnable    = 1'b1;
		readyEnable  = 1'b1;
		readyDelay   = 0;
		expectedCmds = 0;
		repeat (5) @(posedge CLK);
		rst <= 1'b0;

		////////////////////////////////////////////////////////////
		// Power-up wait
		lowCycles = 0;
		do
		begin
			@(posedge CLK);
			checkQuiet("power-up");
			if (!ready)
				lowCycles++;
			if (lowCycles > PowerUp + 4)
				stopRun("ready did not rise after the power-up wait");
		end
		while (!ready);
		checkFlag("ready held low through power-up", 1'b1, lowCycles >= PowerUp);

		////////////////////////////////////////////////////////////
		// Measurements
		for (int run = 0; run < NumRuns; run++)
		begin
			value      = rawSample_t'($random(seed));
			faultDraw  = int'($unsigned($random(seed)) % 20); // 0 no ack, 1 never ready
			expectGood = (faultDraw > 1);
			sendExtra  = 1'($random(seed));
			extraAt    = 2 + int'($unsigned($random(seed)) % 25); // Inside the start pattern
			@(posedge CLK);
			modelValue  <= value;
			readyDelay  <= int'($unsigned($random(seed)) % 61);
			ackEnable   <= (faultDraw != 0);
			readyEnable <= (faultDraw != 1);
			@(posedge CLK);
			startMeas <= 1'b1;
			@(posedge CLK);
			startMeas <= 1'b0;
			expectedCmds++;

			waitCycles = 0;
			gotRaw     = 1'b0;
			gotErr     = 1'b0;
			while (!gotRaw && !gotErr)
			begin
				@(posedge CLK);
				waitCycles++;
				if (waitCycles == extraAt)
				begin
					checkFlag($sformatf("run %0d busy at extra start", run), 1'b1, busy);
					startMeas <= sendExtra; // Should be ignored
				end
				if (waitCycles == extraAt + 1)
					startMeas <= 1'b0;
				gotRaw = rawValid;
				gotErr = sensorError;
				if (waitCycles > MeasBound)
					stopRun($sformatf("Run %0d gave neither rawValid nor sensorError", run));
			end
			checkFlag($sformatf("run %0d rawValid", run), expectGood, gotRaw);
			checkFlag($sformatf("run %0d sensorError", run), !expectGood, gotErr);
			if (expectGood)
				checkRaw($sformatf("run %0d rawValue", run), value, rawValue);

			// BCD strobe lands 13 cycles after rawValid
			for (int k = 1; k <= 13; k++)
			begin
				@(posedge CLK);
				if (k == 1)
					checkFlag($sformatf("run %0d busy falls", run), 1'b0, busy);
				checkFlag($sformatf("run %0d single result", run), 1'b0, rawValid || sensorError);
				checkFlag($sformatf("run %0d bcdValid at %0d", run, k), expectGood && k == 13,
					bcdValid);
			end
			if (expectGood)
				checkBcd($sformatf("run %0d humidityBcd", run), decimalDigits(value), humidityBcd);

			repeat (20)
			begin
				@(posedge CLK);
				checkQuiet($sformatf("run %0d idle", run));
			end
			checkCount($sformatf("run %0d commands at sensor", run), expectedCmds, cmdCount);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: tb/sht10Model.sv
////////////////////////////////////////////////////////////
// Behavioural SHT10 sensor for the testbench
// Decodes start pattern and command, acknowledges, signals
// ready after a set delay and returns a programmable sample
////////////////////////////////////////////////////////////

module sht10Model (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  sck,
	input  logic                  sdaDrive,    // Master pull-down
	output logic                  sdaIn,       // Resolved line level
	input  sensorPkg::rawSample_t sampleValue,
	input  logic                  ackEnable,   // Low withholds the command ack
	input  logic                  readyEnable, // Low never signals ready
	input  int                    readyDelay,  // Cycles from ack release to ready
	output int                    cmdCount,    // Commands decoded so far
	output logic                  busError
);
	import sensorPkg::*;

	localparam logic [7:0] HumidityCmd = 8'b000_00101;

	typedef enum logic [2:0] {MIdle, MStart, MCmd, MAckWait, MAckHold, MBusy, MRead} phase_t;

	phase_t              phase;
	logic                pull;        // Sensor pulls the line low
	logic                prevSck;
	logic                prevLine;
	logic                sawLowClock; // Clock went low inside the start pattern
	logic [7:0]          cmdShift;
	int                  bitCount;
	int                  delayCount;
	int                  readSlot;    // 0-7 byte one, 8 ack, 9-16 byte two, 17 no ack
	logic [ReadBits-1:0] readWord;
	logic                line;
	logic                sckRise;
	logic                sckFall;

	assign line     = !(sdaDrive || pull); // Pull-up outside, wired-AND
	assign sdaIn    = line;
	assign sckRise  = sck && !prevSck;
	assign sckFall  = !sck && prevSck;
	assign readWord = {{(ReadBits-RawWidth){1'b0}}, sampleValue}; // Pad bits on top

	// Sensor pull level for a read slot
	function automatic logic slotPull(input int slot, input logic [ReadBits-1:0] word);
		if (slot == 8 || slot >= 17)
			return 1'b0; // Master owns the ack slots
		else if (slot < 8)
			return !word[15-slot];
		else
			return !word[16-slot];
	endfunction

	always @(posedge CLK)
	begin
		prevSck  <= sck;
		prevLine <= line;
		if (rst)
		begin
			phase    <= MIdle;
			pull     <= 1'b0;
			cmdCount <= 0;
			busError <= 1'b0;
		end
		else
			case (phase)
				MIdle:
					if (sck && prevSck && prevLine && !line)
					begin
						phase       <= MStart; // Data fell with clock high
						sawLowClock <= 1'b0;
					end
				MStart:
				begin
					if (!sck)
						sawLowClock <= 1'b1;
					if (sck && prevSck && !prevLine && line)
					begin
						if (sawLowClock)
						begin
							phase    <= MCmd;
							bitCount <= 0;
						end
						else
						begin
							$display("Sensor model: data rose before the clock pulsed low in start");
							busError <= 1'b1;
						end
					end
				end
				MCmd:
					if (sckRise)
					begin
						cmdShift <= {cmdShift[6:0], line}; // MSB first
						bitCount <= bitCount + 1;
						if (bitCount == 7)
						begin
							phase    <= MAckWait;
							cmdCount <= cmdCount + 1;
							if ({cmdShift[6:0], line} != HumidityCmd)
							begin
								$display("Sensor model: command %b is not %b",
									{cmdShift[6:0], line}, HumidityCmd);
								busError <= 1'b1;
							end
						end
					end
				MAckWait:
					if (sckFall)
					begin
						phase <= MAckHold;
						pull  <= ackEnable; // Held through the ninth slot
					end
				MAckHold:
					if (sckFall)
					begin
						pull       <= 1'b0; // Release, then measure
						delayCount <= 0;
						phase      <= (ackEnable && readyEnable) ? MBusy : MIdle;
					end
				MBusy:
					if (delayCount >= readyDelay)
					begin
						pull     <= slotPull(0, readWord); // Ready low doubles as first pad bit
						readSlot <= 0;
						phase    <= MRead;
					end
					else
						delayCount <= delayCount + 1;
				MRead:
				begin
					if (sckRise && readSlot == 8 && line)
					begin
						$display("Sensor model: master did not acknowledge the first data byte");
						busError <= 1'b1;
					end
					if (sckRise && readSlot == 17 && !line)
					begin
						$display("Sensor model: master acknowledged the last data byte");
						busError <= 1'b1;
					end
					if (sckFall)
					begin
						readSlot <= readSlot + 1;
						pull     <= slotPull(readSlot + 1, readWord); // Change after sck falls
						if (readSlot == 17)
							phase <= MIdle;
					end
				end
				default:
					phase <= MIdle;
			endcase
	end

endmodule

// File: verilog/sht10Top.sv
////////////////////////////////////////////////////////////
// SHT10 humidity front end
// Slot timer, measurement sequencer and BCD converter
////////////////////////////////////////////////////////////

module sht10Top #(
	parameter int HalfSlotCycles       = busTimingPkg::DefHalfSlotCycles,
	parameter int PowerUpCycles        = busTimingPkg::DefPowerUpCycles,
	parameter int MeasureTimeoutCycles = busTimingPkg::DefMeasureTimeoutCycles
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    startMeas,
	input  logic                    sdaIn,       // Pin level, pulled up outside
	output logic                    sck,
	output logic                    sdaDrive,    // Open-drain pull-down enable
	output logic                    busy,
	output logic                    ready,
	output logic                    rawValid,
	output logic                    sensorError,
	output logic                    bcdValid,
	output sensorPkg::rawSample_t   rawValue,
	output sensorPkg::bcdHumidity_t humidityBcd
);

	logic slotRun;    // Sequencer asks for bit slots
	logic sckGate;
	logic sampleTick;
	logic slotEnd;

	shtClockGen #(.HalfSlotCycles(HalfSlotCycles)) clockGen (
		.CLK(CLK), .rst(rst), .slotRun(slotRun), .sckGate(sckGate),
		.sck(sck), .sampleTick(sampleTick), .slotEnd(slotEnd)
	);

	shtSequencer #(
		.PowerUpCycles(PowerUpCycles), .MeasureTimeoutCycles(MeasureTimeoutCycles)
	) sequencer (
		.CLK(CLK), .rst(rst), .startMeas(startMeas), .sdaIn(sdaIn),
		.sampleTick(sampleTick), .slotEnd(slotEnd), .slotRun(slotRun), .sckGate(sckGate),
		.sdaDrive(sdaDrive), .busy(busy), .ready(ready), .rawValid(rawValid),
		.sensorError(sensorError), .rawValue(rawValue)
	);

	// Converts every good sample
	bcdConverter converter (
		.CLK(CLK), .rst(rst), .rawValid(rawValid), .rawValue(rawValue),
		.humidityBcd(humidityBcd), .bcdValid(bcdValid)
	);

endmodule

// File: verilog/bcdConverter.sv
////////////////////////////////////////////////////////////
// Binary to BCD converter for the raw humidity sample
// Serial shift-and-add-three, one bit per cycle
////////////////////////////////////////////////////////////

module bcdConverter (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    rawValid,
	input  sensorPkg::rawSample_t   rawValue,
	output sensorPkg::bcdHumidity_t humidityBcd,
	output logic                    bcdValid
);
	import sensorPkg::*;

	rawSample_t                  binShift;
	bcdHumidity_t                bcdWork;
	bcdHumidity_t                bcdAdjusted;
	bcdHumidity_t                bcdNext;
	logic [$clog2(RawWidth)-1:0] stepCount;
	logic                        running;

	// Add three to every digit of five or more
	function automatic bcdHumidity_t addThree(input bcdHumidity_t bcdIn);
		bcdHumidity_t bcdOut;
		bcdOut = bcdIn;
		for (int d = 0; d < BcdDigits; d++)
			if (bcdIn[4*d +: 4] >= 4'd5)
				bcdOut[4*d +: 4] = bcdIn[4*d +: 4] + 4'd3;
		return bcdOut;
	endfunction

	assign bcdAdjusted = addThree(bcdWork);
	assign bcdNext     = {bcdAdjusted[4*BcdDigits-2:0], binShift[RawWidth-1]};

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			running   <= 1'b0;
			stepCount <= '0;
			bcdValid  <= 1'b0;
		end
		else
		begin
			bcdValid <= 1'b0;
			if (rawValid)
			begin
				running   <= 1'b1; // New sample restarts a running conversion
				stepCount <= '0;
				binShift  <= rawValue;
				bcdWork   <= '0;
			end
			else if (running)
			begin
				stepCount <= stepCount + 1'b1;
				binShift  <= binShift << 1;
				bcdWork   <= bcdNext;
				if (int'(stepCount) == RawWidth - 1)
				begin
					running     <= 1'b0;
					humidityBcd <= bcdNext; // Last step goes straight out
					bcdValid    <= 1'b1;
				end
			end
		end
	end

	assert property (@(posedge CLK) disable iff (rst) bcdValid |-> $past(rawValid, 13));

endmodule

// File: verilog/shtSequencer.sv
////////////////////////////////////////////////////////////
// SHT10 humidity measurement sequencer
// Power-up wait, start pattern, command with ack check,
// ready wait with timeout and two-byte read
// Ends each run with rawValid or sensorError
////////////////////////////////////////////////////////////

module shtSequencer #(
	parameter int PowerUpCycles        = busTimingPkg::DefPowerUpCycles,
	parameter int MeasureTimeoutCycles = busTimingPkg::DefMeasureTimeoutCycles
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  logic                  startMeas,
	input  logic                  sdaIn,
	input  logic                  sampleTick,
	input  logic                  slotEnd,
	output logic                  slotRun,
	output logic                  sckGate,
	output logic                  sdaDrive,   // High pulls the pin low
	output logic                  busy,
	output logic                  ready,
	output logic                  rawValid,
	output logic                  sensorError,
	output sensorPkg::rawSample_t rawValue
);
	import sensorPkg::*;
	import busTimingPkg::*;

	typedef enum logic [3:0] {
		StPowerUp,
		StIdle,
		StStart,
		StCmd,
		StCmdAck,
		StWaitReady,
		StReadByte,
		StMasterAck,
		StSkipAck,
		StDone
	} seqState_t;

	seqState_t                   state;
	logic [$clog2(ReadBits)-1:0] bitCount;   // Start slots, command and read bits
	logic [LongCountWidth-1:0]   longCount;  // Power-up and timeout
	cmdByte_t                    cmdShift;
	rawSample_t                  dataShift;  // Pad bits drop out the top
	logic                        lastBit;    // Line level at the last sample point
	logic                        powerUpDone;
	logic                        timeoutHit;

	assign powerUpDone = (state == StPowerUp) && (int'(longCount) == PowerUpCycles - 1);
	assign timeoutHit  = (state == StWaitReady) &&
		(int'(longCount) == MeasureTimeoutCycles - 1);

	assign ready   = (state != StPowerUp);
	assign busy    = !(state inside {StPowerUp, StIdle});
	assign slotRun = state inside {StStart, StCmd, StCmdAck, StWaitReady,
		StReadByte, StMasterAck, StSkipAck};
	assign sckGate = slotRun && (state != StWaitReady); // No clock while sensor works

	////////////////////////////////////////////////////////////
	// Line sampling and read shift register
	always_ff @(posedge CLK)
	begin
		if (sampleTick)
			lastBit <= sdaIn;
		if (sampleTick && state == StReadByte)
			dataShift <= {dataShift[RawWidth-2:0], sdaIn}; // MSB first
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
			longCount <= '0;
		else if (state == StPowerUp || state == StWaitReady)
			longCount <= longCount + 1'b1;
		else
			longCount <= '0;
	end

	////////////////////////////////////////////////////////////
	// Main FSM
	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state       <= StPowerUp;
			bitCount    <= '0;
			sdaDrive    <= 1'b0;
			rawValid    <= 1'b0;
			sensorError <= 1'b0;
		end
		else
		begin
			rawValid    <= 1'b0;
			sensorError <= 1'b0;
			case (state)
				StPowerUp:
					if (powerUpDone)
						state <= StIdle;
				StIdle:
					if (startMeas)
					begin
						state    <= StStart;
						bitCount <= '0;
						cmdShift <= CmdMeasureHumidity;
					end
				StStart:
				begin
					// Start edges land on the sample point mid-high
					if (sampleTick && int'(bitCount) == 1)
						sdaDrive <= 1'b1; // Data falls while sck high
					if (sampleTick && int'(bitCount) == 3)
						sdaDrive <= 1'b0; // Data rises while sck high
					if (slotEnd)
					begin
						bitCount <= bitCount + 1'b1;
						if (int'(bitCount) == 3)
						begin
							state    <= StCmd;
							bitCount <= '0;
							sdaDrive <= !cmdShift[CmdBits-1];
							cmdShift <= cmdShift << 1;
						end
					end
				end
				StCmd:
					if (slotEnd)
					begin
						if (int'(bitCount) == CmdBits - 1)
						begin
							state    <= StCmdAck;
							sdaDrive <= 1'b0; // Hand the line to the sensor
						end
						else
						begin
							bitCount <= bitCount + 1'b1;
							sdaDrive <= !cmdShift[CmdBits-1];
							cmdShift <= cmdShift << 1;
						end
					end
				StCmdAck:
					if (slotEnd)
					begin
						if (lastBit)
						begin
							state       <= StDone; // No ack
							sensorError <= 1'b1;
						end
						else
							state <= StWaitReady;
					end
				StWaitReady:
					if (timeoutHit)
					begin
						state       <= StDone;
						sensorError <= 1'b1;
					end
					else if (slotEnd && !lastBit)
					begin
						state    <= StReadByte; // Sensor pulled data low
						bitCount <= '0;
					end
				StReadByte:
					if (slotEnd)
					begin
						bitCount <= bitCount + 1'b1;
						if (bitCount[2:0] == 3'b111)
						begin
							if (int'(bitCount) == ReadBits - 1)
								state <= StSkipAck; // No ack after the last byte
							else
							begin
								state    <= StMasterAck;
								sdaDrive <= 1'b1;
							end
						end
					end
				StMasterAck:
					if (slotEnd)
					begin
						state    <= StReadByte;
						sdaDrive <= 1'b0;
					end
				StSkipAck:
					if (slotEnd)
					begin
						state    <= StDone;
						rawValid <= 1'b1;
						rawValue <= dataShift;
					end
				StDone:
					state <= StIdle;
				default:
					state <= StIdle;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (rst) !(rawValid && sensorError));

	// Extra strobes mid-run leave the FSM alone
	assert property (@(posedge CLK) disable iff (rst)
		(startMeas && busy && !slotEnd && !timeoutHit && state != StDone)
		|=> $stable(state));

endmodule

// File: verilog/shtClockGen.sv
////////////////////////////////////////////////////////////
// Bit slot timer for the SHT10 serial clock
// Each slot is two half slots, sck low then high when gated
// Flags the sample point and the last cycle of every slot
////////////////////////////////////////////////////////////

module shtClockGen #(
	parameter int HalfSlotCycles = busTimingPkg::DefHalfSlotCycles
) (
	input  logic CLK,
	input  logic rst,
	input  logic slotRun,    // Slots run while high
	input  logic sckGate,    // Clock pulse in this slot
	output logic sck,
	output logic sampleTick, // Cycle sck rises
	output logic slotEnd     // Last cycle of the slot
);
	import busTimingPkg::*;

	logic [SlotCountWidth-1:0] slotCount;
	logic                      sckNext;

	assign sampleTick = slotRun && (int'(slotCount) == HalfSlotCycles);
	assign slotEnd    = slotRun && (int'(slotCount) == 2 * HalfSlotCycles - 1);

	// High from the sample point, drops one cycle before slot end
	// so data moves with the clock already low
	assign sckNext = slotRun && sckGate &&
		(int'(slotCount) >= HalfSlotCycles - 1) &&
		(int'(slotCount) <= 2 * HalfSlotCycles - 3);

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			slotCount <= '0;
			sck       <= 1'b0;
		end
		else
		begin
			sck <= sckNext;
			if (!slotRun || slotEnd)
				slotCount <= '0; // Next slot starts at zero
			else
				slotCount <= slotCount + 1'b1;
		end
	end

	// Needs at least two cycles per half slot
	assert property (@(posedge CLK) disable iff (rst) !(sampleTick && slotEnd));

endmodule

// File: verilog/busTimingPkg.sv
////////////////////////////////////////////////////////////
// Bus timing defaults for the SHT10 front end
// Cycle counts assume a 50 MHz system clock
////////////////////////////////////////////////////////////

package busTimingPkg;

	// Half bit slot, 250 clocks gives 100 kHz on sck
	localparam int DefHalfSlotCycles = 250;

	// Sensor power-up, 11 ms
	localparam int DefPowerUpCycles = 550000;

	// Longest wait for the sensor to finish, 320 ms
	localparam int DefMeasureTimeoutCycles = 16000000;

	////////////////////////////////////////////////////////////
	// Counter widths
	localparam int SlotCountWidth = 9;  // Holds 2*250-1
	localparam int LongCountWidth = 25; // Holds the timeout count

endpackage

// File: verilog/sensorPkg.sv
////////////////////////////////////////////////////////////
// Sensor definitions for the SHT10 humidity front end
// Command code, frame bit counts, sample and BCD types
////////////////////////////////////////////////////////////

package sensorPkg;

	////////////////////////////////////////////////////////////
	// Frame sizes
	localparam int CmdBits   = 8;  // Address plus command, MSB first
	localparam int ReadBits  = 16; // Two bytes, 4 pad bits then sample
	localparam int RawWidth  = 12; // Humidity resolution
	localparam int BcdDigits = 4;  // Up to 4095

	////////////////////////////////////////////////////////////
	// Types
	typedef logic [RawWidth-1:0]    rawSample_t;   // Raw RH reading
	typedef logic [4*BcdDigits-1:0] bcdHumidity_t; // Thousands digit on top
	typedef logic [CmdBits-1:0]     cmdByte_t;

	// Address 000, command 00101
	localparam cmdByte_t CmdMeasureHumidity = 8'b000_00101;

endpackage
